// File: build.f
+incdir+verilog
verilog/cpu_types_pkg.sv
verilog/stage_if.sv
verilog/control_unit.sv
verilog/register_file.sv
verilog/alu.sv
verilog/hazard_forward_unit.sv
verilog/pipeline_regs.sv
verilog/datapath.sv
tb/tb_memory.sv
tb/tb_datapath.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f build.f --top-module tb_datapath -o tb_datapath_sim
output="$(./obj_dir/tb_datapath_sim)"
echo "$output"

if echo "$output" | grep -qx "Test OK"; then
  exit 0
fi
exit 1

// File: tb/tb_datapath.sv
// testbench top for the pipelined datapath
// clock, reset, store table, port assertions, halt timeout, report
`timescale 1ns/1ns
`include "cpu_macros.svh"

module tb_datapath;
  import cpu_types_pkg::*;

  localparam int    RESET_CYCLES   = 8;
  localparam int    TIMEOUT_CYCLES = 2000;
  localparam int    HOLD_CYCLES    = 20;
  localparam word_t POISON_ADDR    = 32'h0000_03FC;

  logic  clk, rst_n, ihit, dhit, dmemren, dmemwen, halt;
  word_t imemload, dmemload, imemaddr, dmemaddr, dmemstore;
  word_t exp_addr [$];
  word_t exp_data [$];
  int    errors, store_idx, cycles;
  logic  halt_seen;

  initial clk = 1'b0;
  always #20 clk = ~clk;

  datapath datapath_inst (
    .CLK(clk), .rst_n(rst_n), .ihit(ihit), .imemload(imemload),
    .dhit(dhit), .dmemload(dmemload), .imemaddr(imemaddr),
    .dmemren(dmemren), .dmemwen(dmemwen), .dmemaddr(dmemaddr),
    .dmemstore(dmemstore), .halt(halt)
  );

  tb_memory mem_inst (
    .clk(clk), .imemaddr(imemaddr), .ihit(ihit), .imemload(imemload),
    .dmemren(dmemren), .dmemwen(dmemwen), .dmemaddr(dmemaddr),
    .dmemstore(dmemstore), .dhit(dhit), .dmemload(dmemload)
  );

  task automatic report_error(input string msg);
    errors++;
    $display("error at %0t ns: %s", $time, msg);
  endtask

  task automatic add_store(input word_t addr, input word_t data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  // register values worked out from the instruction semantics
  task automatic build_expected;
    word_t r1, r2, r3, r4, r5, r6, r7, r8, r9, r10, r11, r12, r13, r14;
    r1  = 32'd5;
    r2  = r1 | 32'h0000_00F0;
    r3  = {16'h1234, 16'h0000};
    r4  = r3 + r2;
    r5  = r4 - r1;
    r6  = r5 & r2;
    r7  = r6 | r3;
    r8  = ($signed(r1) < $signed(r7)) ? 32'd1 : 32'd0;
    r9  = r8 << 4;
    // addiu sign extends 0xffff
    r10 = 32'hFFFF_FFFF;
    r11 = ($signed(r1) < $signed(r10)) ? 32'd1 : 32'd0;
    // lw reads back what sw r2 put at 0x004
    r12 = r2;
    r13 = r12 + r1;
    r14 = 32'h0000_00A8;
    add_store(32'h28, r11);
    add_store(32'h24, r10);
    add_store(32'h00, r1);
    add_store(32'h04, r2);
    add_store(32'h08, r3);
    add_store(32'h0C, r4);
    add_store(32'h10, r5);
    add_store(32'h14, r6);
    add_store(32'h18, r7);
    add_store(32'h1C, r8);
    add_store(32'h20, r9);
    add_store(32'h2C, r13);
    // right path after not taken bne, then after jr
    add_store(32'h30, r2);
    add_store(32'h34, r14);
  endtask

  task automatic check_reset_state;
    assert (imemaddr == `PC_RESET)
      else report_error($sformatf("imemaddr %h in reset, expected %h", imemaddr, `PC_RESET));
    assert (!dmemren && !dmemwen)
      else report_error("memory request during reset");
    assert (!halt)
      else report_error("halt high during reset");
  endtask

  // ports are settled at the falling edge
  always @(negedge clk)
  begin
    if (rst_n && dmemwen && dhit)
    begin
      assert (dmemaddr != POISON_ADDR)
        else report_error($sformatf("store of %h to poison address", dmemstore));
      assert (store_idx < exp_addr.size())
        else report_error($sformatf("extra store to %h", dmemaddr));
      if (store_idx < exp_addr.size())
      begin
        assert (dmemaddr == exp_addr[store_idx])
          else report_error($sformatf("store %0d address %h, expected %h",
                                      store_idx, dmemaddr, exp_addr[store_idx]));
        assert (dmemstore == exp_data[store_idx])
          else report_error($sformatf("store %0d data %h, expected %h",
                                      store_idx, dmemstore, exp_data[store_idx]));
      end
      store_idx++;
    end
    if (rst_n && halt && !halt_seen)
    begin
      // halt only after the last store
      assert (store_idx == exp_addr.size())
        else report_error($sformatf("halt after %0d stores, expected %0d",
                                    store_idx, exp_addr.size()));
      halt_seen = 1'b1;
    end
    else if (halt_seen)
    begin
      assert (halt)
        else report_error("halt dropped after rising");
      assert (!dmemren && !dmemwen)
        else report_error($sformatf("memory request at %h after halt", dmemaddr));
    end
  end

  initial
  begin
    errors    = 0;
    store_idx = 0;
    cycles    = 0;
    halt_seen = 1'b0;
    rst_n     = 1'b0;
    build_expected();
    for (int i = 0; i < RESET_CYCLES; i++)
    begin
      @(negedge clk);
      check_reset_state();
    end
    @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(negedge clk);
    check_reset_state();
    while (!halt && cycles < TIMEOUT_CYCLES)
    begin
      @(negedge clk);
      cycles++;
    end
    if (!halt)
    begin
      $display("halt never rose within %0d cycles, %0d stores seen, %0d errors",
               TIMEOUT_CYCLES, store_idx, errors);
      $display("Test FAILED");
      $finish;
    end
    else
    begin
      // pipeline must stay frozen
      repeat (HOLD_CYCLES) @(negedge clk);
      assert (store_idx == exp_addr.size())
        else report_error($sformatf("%0d stores in total, expected %0d", store_idx,
                                    exp_addr.size()));
      $display("summary: %0d of %0d stores, %0d errors", store_idx, exp_addr.size(),
               errors);
      if (errors == 0)
        $display("Test OK");
      else
        $display("Test FAILED");
      $finish;
    end
  end

endmodule

// File: tb/tb_memory.sv
// instruction rom holding the test program
// data ram with random dhit wait states
`timescale 1ns/1ns

module tb_memory (
  input  logic                 clk,
  input  cpu_types_pkg::word_t imemaddr,
  output logic                 ihit,
  output cpu_types_pkg::word_t imemload,
  input  logic                 dmemren,
  input  logic                 dmemwen,
  input  cpu_types_pkg::word_t dmemaddr,
  input  cpu_types_pkg::word_t dmemstore,
  output logic                 dhit,
  output cpu_types_pkg::word_t dmemload
);
  import cpu_types_pkg::*;

  word_t rom [0:63];
  word_t ram [0:255];
  integer seed;
  logic [1:0] waited, target;
  // port state taken at the falling edge
  logic  req_s, hit_s, wen_s;
  word_t addr_s, data_s;

  function automatic word_t enc_r(input logic [4:0] rs, rt, rd, shamt,
                                  input logic [5:0] funct);
    return {6'h00, rs, rt, rd, shamt, funct};
  endfunction

  function automatic word_t enc_i(input logic [5:0] op, input logic [4:0] rs, rt,
                                  input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word_t enc_j(input logic [5:0] op, input logic [25:0] target_w);
    return {op, target_w};
  endfunction

  initial
  begin
    word_t poison;
    seed   = 98;
    waited = 2'd0;
    target = 2'($unsigned($random(seed)) % 32'd3);
    req_s  = 1'b0;
    hit_s  = 1'b0;
    wen_s  = 1'b0;
    addr_s = '0;
    data_s = '0;
    // unused slots and wrong paths all hold a store to 0x3fc
    poison = enc_i(SW, 5'd0, 5'd1, 16'h03FC);
    for (int i = 0; i < 64; i++)
      rom[i] = poison;
    for (int i = 0; i < 256; i++)
      ram[i] = 32'hC0DE_0000 ^ (i << 2);
    // dependent alu and immediate chain
    rom[0]  = enc_i(ADDIU, 5'd0, 5'd1, 16'h0005);
    rom[1]  = enc_i(ORI, 5'd1, 5'd2, 16'h00F0);
    rom[2]  = enc_i(LUI, 5'd0, 5'd3, 16'h1234);
    rom[3]  = enc_r(5'd3, 5'd2, 5'd4, 5'd0, ADDU);
    rom[4]  = enc_r(5'd4, 5'd1, 5'd5, 5'd0, SUBU);
    rom[5]  = enc_r(5'd5, 5'd2, 5'd6, 5'd0, AND);
    rom[6]  = enc_r(5'd6, 5'd3, 5'd7, 5'd0, OR);
    rom[7]  = enc_r(5'd1, 5'd7, 5'd8, 5'd0, SLT);
    rom[8]  = enc_r(5'd0, 5'd8, 5'd9, 5'd4, SLL);
    rom[9]  = enc_i(ADDIU, 5'd0, 5'd10, 16'hFFFF);
    rom[10] = enc_r(5'd1, 5'd10, 5'd11, 5'd0, SLT);
    // store data forwarded from ex/mem, then read through the write port
    rom[11] = enc_i(SW, 5'd0, 5'd11, 16'h0028);
    rom[12] = enc_i(SW, 5'd0, 5'd10, 16'h0024);
    for (int i = 0; i < 9; i++)
      rom[13 + i] = enc_i(SW, 5'd0, 5'(i + 1), 16'(4 * i));
    // load-use pair
    rom[22] = enc_i(LW, 5'd0, 5'd12, 16'h0004);
    rom[23] = enc_r(5'd12, 5'd1, 5'd13, 5'd0, ADDU);
    rom[24] = enc_i(SW, 5'd0, 5'd13, 16'h002C);
    // taken beq to 29, not taken bne, j to 36, jr to 42
    rom[25] = enc_i(BEQ, 5'd1, 5'd1, 16'd3);
    rom[29] = enc_i(BNE, 5'd1, 5'd1, 16'd3);
    rom[30] = enc_i(SW, 5'd0, 5'd2, 16'h0030);
    rom[31] = enc_j(J, 26'd36);
    rom[36] = enc_i(ADDIU, 5'd0, 5'd14, 16'h00A8);
    rom[37] = enc_r(5'd14, 5'd0, 5'd0, 5'd0, JR);
    rom[42] = enc_i(SW, 5'd0, 5'd14, 16'h0034);
    rom[43] = enc_j(HALT, 26'd0);
  end

  assign ihit     = 1'b1;
  assign imemload = rom[imemaddr[7:2]];
  assign dmemload = ram[dmemaddr[9:2]];
  // zero wait state request hits in the same cycle
  assign dhit     = (dmemren || dmemwen) && (waited == target);

  always @(negedge clk)
  begin
    req_s  = dmemren || dmemwen;
    hit_s  = dhit;
    wen_s  = dmemwen;
    addr_s = dmemaddr;
    data_s = dmemstore;
  end

  // state moves just after the edge that ends the access
  always @(posedge clk)
  begin
    #2;
    if (req_s && hit_s)
    begin
      if (wen_s)
        ram[addr_s[9:2]] = data_s;
      waited = 2'd0;
      target = 2'($unsigned($random(seed)) % 32'd3);
    end
    else if (req_s)
      waited = waited + 2'd1;
  end

endmodule

// File: verilog/datapath.sv
// top level five stage pipelined datapath
// pc and next pc mux, extender, forward and operand muxes
// branch and jump targets, redirect, memory ports, writeback mux
`timescale 1ns/1ns
`include "cpu_macros.svh"

module datapath (
  input  logic                 CLK,
  input  logic                 rst_n,
  input  logic                 ihit,
  input  cpu_types_pkg::word_t imemload,
  input  logic                 dhit,
  input  cpu_types_pkg::word_t dmemload,
  output cpu_types_pkg::word_t imemaddr,
  output logic                 dmemren,
  output logic                 dmemwen,
  output cpu_types_pkg::word_t dmemaddr,
  output cpu_types_pkg::word_t dmemstore,
  output logic                 halt
);
  import cpu_types_pkg::*;

  word_t    pc, npc, pc_next;
  logic     advance, stall, redirect;
  opcode_t  cu_op_class;
  alu_op_t  cu_alu_op;
  alu_src_t cu_alu_src;
  wb_sel_t  cu_wb_sel;
  pc_src_t  cu_pc_src;
  logic     cu_sign_ext, cu_wen, cu_dren, cu_dwen, cu_halt_op, cu_bne;
  regsel_t  cu_rsel1, cu_rsel2, cu_wsel;
  logic [15:0] cu_imm16;
  logic [4:0]  cu_shamt;
  logic [25:0] cu_jaddr26;
  fwd_sel_t fwd_a, fwd_b;
  word_t    exmem_val, wdat, opa, opb_raw, opb, alu_res;
  logic     alu_zero, taken;

  stage_if stif ();

  control_unit cu_inst (
    .instr(stif.instr_o1), .op_class(cu_op_class), .alu_op(cu_alu_op),
    .alu_src(cu_alu_src), .wb_sel(cu_wb_sel), .pc_src(cu_pc_src),
    .sign_ext(cu_sign_ext), .wen(cu_wen), .dren(cu_dren), .dwen(cu_dwen),
    .halt_op(cu_halt_op), .bne(cu_bne), .rsel1(cu_rsel1), .rsel2(cu_rsel2),
    .wsel(cu_wsel), .imm16(cu_imm16), .shamt(cu_shamt), .jaddr26(cu_jaddr26)
  );

  // writes wait for the pipeline to move
  register_file rf_inst (
    .CLK(CLK), .rst_n(rst_n), .wen(stif.wen_o4 & advance), .wsel(stif.wsel_o4),
    .rsel1(cu_rsel1), .rsel2(cu_rsel2), .wdat(wdat),
    .rdat1(stif.rdat1_i2), .rdat2(stif.rdat2_i2)
  );

  alu alu_inst (.op(stif.alu_op_o2), .a(opa), .b(opb), .result(alu_res), .zero(alu_zero));

  hazard_forward_unit hfu_inst (
    .dec_rsel1(cu_rsel1), .dec_rsel2(cu_rsel2), .stif(stif.hu),
    .memwb_wen(stif.wen_o4), .memwb_wsel(stif.wsel_o4),
    .stall(stall), .fwd_a(fwd_a), .fwd_b(fwd_b)
  );

  pipeline_regs pr_inst (
    .CLK(CLK), .rst_n(rst_n), .advance(advance), .stall(stall),
    .redirect(redirect), .stif(stif.pr)
  );

  // freeze on fetch miss, halt, or pending data access
  assign advance  = ihit & ~stif.halt_o & (~(stif.dren_o3 | stif.dwen_o3) | dhit);
  assign redirect = (stif.pc_src_o3 != PC_ADD4);

  // fetch
  assign npc      = pc + 32'd4;
  assign imemaddr = pc;
  assign stif.npc_i1   = npc;
  assign stif.instr_i1 = imemload;

  // redirect beats the load-use hold
  always_comb
  begin
    case (stif.pc_src_o3)
      PC_BRANCH: pc_next = stif.branch_addr_o3;
      PC_JUMP:   pc_next = stif.jump_addr_o3;
      PC_JR:     pc_next = stif.jr_addr_o3;
      default:   pc_next = stall ? pc : npc;
    endcase
  end

  always_ff @(posedge CLK or negedge rst_n)
  begin
    if (!rst_n)
      pc <= `PC_RESET;
    else if (advance)
      pc <= pc_next;
  end

  // decode stage sign or zero extend
  assign stif.ext32_i2   = cu_sign_ext ? {{16{cu_imm16[15]}}, cu_imm16} : {16'h0000, cu_imm16};
  assign stif.lui_i2     = (cu_op_class == LUI) ? {cu_imm16, 16'h0000} : '0;
  assign stif.npc_i2     = stif.npc_o1;
  assign stif.shamt_i2   = cu_shamt;
  assign stif.jaddr26_i2 = cu_jaddr26;
  assign stif.rsel1_i2   = cu_rsel1;
  assign stif.rsel2_i2   = cu_rsel2;
  assign stif.wsel_i2    = cu_wsel;
  assign stif.alu_op_i2  = cu_alu_op;
  assign stif.alu_src_i2 = cu_alu_src;
  assign stif.wb_sel_i2  = cu_wb_sel;
  assign stif.pc_src_i2  = cu_pc_src;
  assign stif.bne_i2     = cu_bne;
  assign stif.wen_i2     = cu_wen;
  assign stif.dren_i2    = cu_dren;
  assign stif.dwen_i2    = cu_dwen;
  assign stif.halt_i2    = cu_halt_op;

  // forward value from ex/mem is the alu result or lui
  assign exmem_val = (stif.wb_sel_o3 == WB_LUI) ? stif.lui_o3 : stif.aluout_o3;

  always_comb
  begin
    case (fwd_a)
      FWD_EXMEM: opa = exmem_val;
      FWD_MEMWB: opa = wdat;
      default:   opa = stif.rdat1_o2;
    endcase
    // forward before the source mux since store data needs it too
    case (fwd_b)
      FWD_EXMEM: opb_raw = exmem_val;
      FWD_MEMWB: opb_raw = wdat;
      default:   opb_raw = stif.rdat2_o2;
    endcase
    case (stif.alu_src_o2)
      SRC_SHAMT: opb = word_t'(stif.shamt_o2);
      SRC_EXT:   opb = stif.ext32_o2;
      default:   opb = opb_raw;
    endcase
  end

  // not taken branch falls back to add4
  assign taken = stif.bne_o2 ? ~alu_zero : alu_zero;
  assign stif.pc_src_i3 = (stif.pc_src_o2 == PC_BRANCH && !taken) ? PC_ADD4 : stif.pc_src_o2;
  assign stif.branch_addr_i3 = stif.npc_o2 + (stif.ext32_o2 << 2);
  assign stif.jump_addr_i3   = {stif.npc_o2[31:28], stif.jaddr26_o2, 2'b00};
  assign stif.jr_addr_i3     = opa;
  assign stif.aluout_i3      = alu_res;
  assign stif.dstore_i3      = opb_raw;
  assign stif.lui_i3         = stif.lui_o2;
  assign stif.wsel_i3        = stif.wsel_o2;
  assign stif.wb_sel_i3      = stif.wb_sel_o2;
  assign stif.wen_i3         = stif.wen_o2;
  assign stif.dren_i3        = stif.dren_o2;
  assign stif.dwen_i3        = stif.dwen_o2;
  assign stif.halt_i3        = stif.halt_o2;

  // memory ports straight off ex/mem
  assign dmemren   = stif.dren_o3;
  assign dmemwen   = stif.dwen_o3;
  assign dmemaddr  = stif.aluout_o3;
  assign dmemstore = stif.dstore_o3;
  assign halt      = stif.halt_o;

  assign stif.aluout_i4 = stif.aluout_o3;
  assign stif.dload_i4  = dmemload;
  assign stif.lui_i4    = stif.lui_o3;
  assign stif.wsel_i4   = stif.wsel_o3;
  assign stif.wb_sel_i4 = stif.wb_sel_o3;
  assign stif.wen_i4    = stif.wen_o3;

  // writeback
  always_comb
  begin
    case (stif.wb_sel_o4)
      WB_DATA: wdat = stif.dload_o4;
      WB_LUI:  wdat = stif.lui_o4;
      default: wdat = stif.aluout_o4;
    endcase
  end

endmodule

// File: verilog/pipeline_regs.sv
// if/id, id/ex, ex/mem and mem/wb latches
// hold on back-pressure, bubble on load-use, flush on redirect
// sticky halt flag
`timescale 1ns/1ns

module pipeline_regs (
  input logic CLK,
  input logic rst_n,
  input logic advance,
  input logic stall,
  input logic redirect,
  stage_if.pr stif
);
  import cpu_types_pkg::*;

  logic bubble_ex;

  // id/ex gets a bubble on either load-use or redirect
  assign bubble_ex = stall | redirect;

  // control state clears to bubbles
  always_ff @(posedge CLK or negedge rst_n)
  begin
    if (!rst_n)
    begin
      stif.instr_o1  <= '0;
      stif.pc_src_o2 <= PC_ADD4;
      stif.wen_o2    <= 1'b0;
      stif.dren_o2   <= 1'b0;
      stif.dwen_o2   <= 1'b0;
      stif.halt_o2   <= 1'b0;
      stif.pc_src_o3 <= PC_ADD4;
      stif.wen_o3    <= 1'b0;
      stif.dren_o3   <= 1'b0;
      stif.dwen_o3   <= 1'b0;
      stif.wen_o4    <= 1'b0;
      stif.halt_o    <= 1'b0;
    end
    else if (advance)
    begin
      // zero instr word decodes as a no-op
      if (redirect)
        stif.instr_o1 <= '0;
      else if (!stall)
        stif.instr_o1 <= stif.instr_i1;
      stif.pc_src_o2 <= bubble_ex ? PC_ADD4 : stif.pc_src_i2;
      stif.wen_o2    <= stif.wen_i2 & ~bubble_ex;
      stif.dren_o2   <= stif.dren_i2 & ~bubble_ex;
      stif.dwen_o2   <= stif.dwen_i2 & ~bubble_ex;
      stif.halt_o2   <= stif.halt_i2 & ~bubble_ex;
      // ex/mem flush kills the instr behind the branch
      stif.pc_src_o3 <= redirect ? PC_ADD4 : stif.pc_src_i3;
      stif.wen_o3    <= stif.wen_i3 & ~redirect;
      stif.dren_o3   <= stif.dren_i3 & ~redirect;
      stif.dwen_o3   <= stif.dwen_i3 & ~redirect;
      stif.wen_o4    <= stif.wen_i4;
      // halt reaching ex/mem freezes everything, so it never clears
      if (stif.halt_i3 && !redirect)
        stif.halt_o <= 1'b1;
    end
  end

  // payload fields only matter while their enables are set
  always_ff @(posedge CLK)
  begin
    if (advance)
    begin
      if (!stall)
        stif.npc_o1 <= stif.npc_i1;
      stif.npc_o2         <= stif.npc_i2;
      stif.rdat1_o2       <= stif.rdat1_i2;
      stif.rdat2_o2       <= stif.rdat2_i2;
      stif.ext32_o2       <= stif.ext32_i2;
      stif.lui_o2         <= stif.lui_i2;
      stif.shamt_o2       <= stif.shamt_i2;
      stif.jaddr26_o2     <= stif.jaddr26_i2;
      stif.rsel1_o2       <= stif.rsel1_i2;
      stif.rsel2_o2       <= stif.rsel2_i2;
      stif.wsel_o2        <= stif.wsel_i2;
      stif.alu_op_o2      <= stif.alu_op_i2;
      stif.alu_src_o2     <= stif.alu_src_i2;
      stif.wb_sel_o2      <= stif.wb_sel_i2;
      stif.bne_o2         <= stif.bne_i2;
      stif.aluout_o3      <= stif.aluout_i3;
      stif.dstore_o3      <= stif.dstore_i3;
      stif.lui_o3         <= stif.lui_i3;
      stif.branch_addr_o3 <= stif.branch_addr_i3;
      stif.jump_addr_o3   <= stif.jump_addr_i3;
      stif.jr_addr_o3     <= stif.jr_addr_i3;
      stif.wsel_o3        <= stif.wsel_i3;
      stif.wb_sel_o3      <= stif.wb_sel_i3;
      // load data captured as the load leaves ex/mem
      stif.aluout_o4      <= stif.aluout_i4;
      stif.dload_o4       <= stif.dload_i4;
      stif.lui_o4         <= stif.lui_i4;
      stif.wsel_o4        <= stif.wsel_i4;
      stif.wb_sel_o4      <= stif.wb_sel_i4;
    end
  end

endmodule

// File: verilog/hazard_forward_unit.sv
// load-use stall detection
// forward selects for both execute operands
`timescale 1ns/1ns

module hazard_forward_unit (
  input  cpu_types_pkg::regsel_t  dec_rsel1, dec_rsel2,
  stage_if.hu                     stif,
  input  logic                    memwb_wen,
  input  cpu_types_pkg::regsel_t  memwb_wsel,
  output logic                    stall,
  output cpu_types_pkg::fwd_sel_t fwd_a, fwd_b
);
  import cpu_types_pkg::*;

  // load in id/ex feeding the instr in decode
  // one bubble, then mem/wb forwarding covers it
  assign stall = stif.dren_o2 && (stif.wsel_o2 != '0) &&
                 ((stif.wsel_o2 == dec_rsel1) || (stif.wsel_o2 == dec_rsel2));

  // ex/mem is younger, so it wins over mem/wb
  function automatic fwd_sel_t pick(input regsel_t src);
    if (src == '0)
      return FWD_RDAT;
    else if (stif.wen_o3 && stif.wsel_o3 == src)
      return FWD_EXMEM;
    else if (memwb_wen && memwb_wsel == src)
      return FWD_MEMWB;
    else
      return FWD_RDAT;
  endfunction

  assign fwd_a = pick(stif.rsel1_o2);
  assign fwd_b = pick(stif.rsel2_o2);

endmodule

// File: verilog/alu.sv
// arithmetic and logic unit
// add, sub, and, or, signed slt, sll by b[4:0], zero flag
`timescale 1ns/1ns

module alu (
  input  cpu_types_pkg::alu_op_t op,
  input  cpu_types_pkg::word_t   a, b,
  output cpu_types_pkg::word_t   result,
  output logic                   zero
);
  import cpu_types_pkg::*;

  always_comb
  begin
    case (op)
      ALU_SUB: result = a - b;
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      // result is 0 or 1 from a signed compare
      ALU_SLT: result = word_t'($signed(a) < $signed(b));
      ALU_SLL: result = a << b[4:0];
      default: result = a + b;
    endcase
  end

  // feeds beq/bne
  assign zero = (result == '0);

endmodule

// File: verilog/register_file.sv
// 32 entry register file with r0 hardwired to zero
// two read ports with write-through from the write port
`timescale 1ns/1ns
`include "cpu_macros.svh"

module register_file (
  input  logic                   CLK,
  input  logic                   rst_n,
  input  logic                   wen,
  input  cpu_types_pkg::regsel_t wsel, rsel1, rsel2,
  input  cpu_types_pkg::word_t   wdat,
  output cpu_types_pkg::word_t   rdat1, rdat2
);
  import cpu_types_pkg::*;

  // r0 has no storage
  word_t regs [1:`REG_N-1];

  always_ff @(posedge CLK or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 1; i < `REG_N; i++)
        regs[i] <= '0;
    end
    else if (wen && wsel != '0)
      regs[wsel] <= wdat;
  end

  // same cycle write is visible to decode
  function automatic word_t read_port(input regsel_t sel);
    if (sel == '0)
      return '0;
    else if (wen && sel == wsel)
      return wdat;
    else
      return regs[sel];
  endfunction

  assign rdat1 = read_port(rsel1);
  assign rdat2 = read_port(rsel2);

endmodule

// File: verilog/control_unit.sv
// instruction decoder
// opcode and funct to alu, source, writeback and next pc selects
// register selects, immediates, memory and halt enables
`timescale 1ns/1ns

module control_unit (
  input  cpu_types_pkg::word_t    instr,
  output cpu_types_pkg::opcode_t  op_class,
  output cpu_types_pkg::alu_op_t  alu_op,
  output cpu_types_pkg::alu_src_t alu_src,
  output cpu_types_pkg::wb_sel_t  wb_sel,
  output cpu_types_pkg::pc_src_t  pc_src,
  output logic                    sign_ext, wen, dren, dwen, halt_op, bne,
  output cpu_types_pkg::regsel_t  rsel1, rsel2, wsel,
  output logic [15:0]             imm16,
  output logic [4:0]              shamt,
  output logic [25:0]             jaddr26
);
  import cpu_types_pkg::*;

  funct_t funct;
  logic   wen_raw;

  assign op_class = opcode_t'(instr[31:26]);
  assign funct    = funct_t'(instr[5:0]);
  assign rsel2    = instr[20:16];
  assign imm16    = instr[15:0];
  assign shamt    = instr[10:6];
  assign jaddr26  = instr[25:0];

  // a write to r0 is dropped here, so the all zero bubble is a no-op
  assign wen = wen_raw && (wsel != '0);

  always_comb
  begin
    // defaults decode as a no-op
    alu_op   = ALU_ADD;
    alu_src  = SRC_RDAT2;
    wb_sel   = WB_ALUOUT;
    pc_src   = PC_ADD4;
    sign_ext = 1'b0;
    wen_raw  = 1'b0;
    dren     = 1'b0;
    dwen     = 1'b0;
    halt_op  = 1'b0;
    bne      = 1'b0;
    rsel1    = instr[25:21];
    // stores and branches leave r0 as dest
    wsel     = '0;
    case (op_class)
      RTYPE:
      begin
        wsel    = instr[15:11];
        wen_raw = 1'b1;
        case (funct)
          ADDU: alu_op = ALU_ADD;
          SUBU: alu_op = ALU_SUB;
          AND:  alu_op = ALU_AND;
          OR:   alu_op = ALU_OR;
          SLT:  alu_op = ALU_SLT;
          SLL:
          begin
            // shifts rt, so rt goes on the a side
            alu_op  = ALU_SLL;
            alu_src = SRC_SHAMT;
            rsel1   = instr[20:16];
          end
          JR:
          begin
            pc_src  = PC_JR;
            wen_raw = 1'b0;
          end
          default: wen_raw = 1'b0;
        endcase
      end
      ADDIU:
      begin
        wsel     = instr[20:16];
        wen_raw  = 1'b1;
        alu_src  = SRC_EXT;
        sign_ext = 1'b1;
      end
      ORI:
      begin
        wsel    = instr[20:16];
        wen_raw = 1'b1;
        alu_op  = ALU_OR;
        alu_src = SRC_EXT;
      end
      LUI:
      begin
        wsel    = instr[20:16];
        wen_raw = 1'b1;
        wb_sel  = WB_LUI;
      end
      LW:
      begin
        wsel     = instr[20:16];
        wen_raw  = 1'b1;
        alu_src  = SRC_EXT;
        sign_ext = 1'b1;
        dren     = 1'b1;
        wb_sel   = WB_DATA;
      end
      SW:
      begin
        alu_src  = SRC_EXT;
        sign_ext = 1'b1;
        dwen     = 1'b1;
      end
      BEQ, BNE:
      begin
        // compare by subtract, offset is signed
        alu_op   = ALU_SUB;
        sign_ext = 1'b1;
        pc_src   = PC_BRANCH;
        bne      = (op_class == BNE);
      end
      J:       pc_src  = PC_JUMP;
      HALT:    halt_op = 1'b1;
      default: ;
    endcase
  end

endmodule

// File: verilog/stage_if.sv
// pipeline register bundle
// _i fields feed a latch, _o fields leave it
// modports for the latches, the datapath and the hazard unit
`timescale 1ns/1ns

interface stage_if;
  import cpu_types_pkg::*;

  // if/id
  word_t npc_i1, npc_o1, instr_i1, instr_o1;

  // id/ex
  word_t npc_i2, npc_o2, rdat1_i2, rdat1_o2, rdat2_i2, rdat2_o2;
  word_t ext32_i2, ext32_o2, lui_i2, lui_o2;
  logic [4:0] shamt_i2, shamt_o2;
  logic [25:0] jaddr26_i2, jaddr26_o2;
  regsel_t rsel1_i2, rsel1_o2, rsel2_i2, rsel2_o2, wsel_i2, wsel_o2;
  alu_op_t alu_op_i2, alu_op_o2;
  alu_src_t alu_src_i2, alu_src_o2;
  wb_sel_t wb_sel_i2, wb_sel_o2;
  pc_src_t pc_src_i2, pc_src_o2;
  logic bne_i2, bne_o2, wen_i2, wen_o2, dren_i2, dren_o2, dwen_i2, dwen_o2;
  logic halt_i2, halt_o2;

  // ex/mem
  word_t aluout_i3, aluout_o3, dstore_i3, dstore_o3, lui_i3, lui_o3;
  word_t branch_addr_i3, branch_addr_o3, jump_addr_i3, jump_addr_o3;
  word_t jr_addr_i3, jr_addr_o3;
  regsel_t wsel_i3, wsel_o3;
  wb_sel_t wb_sel_i3, wb_sel_o3;
  pc_src_t pc_src_i3, pc_src_o3;
  logic wen_i3, wen_o3, dren_i3, dren_o3, dwen_i3, dwen_o3;
  // halt has no ex/mem copy, only the sticky flag
  logic halt_i3, halt_o;

  // mem/wb
  word_t aluout_i4, aluout_o4, dload_i4, dload_o4, lui_i4, lui_o4;
  regsel_t wsel_i4, wsel_o4;
  wb_sel_t wb_sel_i4, wb_sel_o4;
  logic wen_i4, wen_o4;

  modport pr (
    input  npc_i1, instr_i1, npc_i2, rdat1_i2, rdat2_i2, ext32_i2, lui_i2, shamt_i2,
           jaddr26_i2, rsel1_i2, rsel2_i2, wsel_i2, alu_op_i2, alu_src_i2, wb_sel_i2,
           pc_src_i2, bne_i2, wen_i2, dren_i2, dwen_i2, halt_i2, aluout_i3, dstore_i3,
           lui_i3, branch_addr_i3, jump_addr_i3, jr_addr_i3, wsel_i3, wb_sel_i3,
           pc_src_i3, wen_i3, dren_i3, dwen_i3, halt_i3, aluout_i4, dload_i4, lui_i4,
           wsel_i4, wb_sel_i4, wen_i4,
    output npc_o1, instr_o1, npc_o2, rdat1_o2, rdat2_o2, ext32_o2, lui_o2, shamt_o2,
           jaddr26_o2, rsel1_o2, rsel2_o2, wsel_o2, alu_op_o2, alu_src_o2, wb_sel_o2,
           pc_src_o2, bne_o2, wen_o2, dren_o2, dwen_o2, halt_o2, aluout_o3, dstore_o3,
           lui_o3, branch_addr_o3, jump_addr_o3, jr_addr_o3, wsel_o3, wb_sel_o3,
           pc_src_o3, wen_o3, dren_o3, dwen_o3, halt_o, aluout_o4, dload_o4, lui_o4,
           wsel_o4, wb_sel_o4, wen_o4
  );

  modport dp (
    output npc_i1, instr_i1, npc_i2, rdat1_i2, rdat2_i2, ext32_i2, lui_i2, shamt_i2,
           jaddr26_i2, rsel1_i2, rsel2_i2, wsel_i2, alu_op_i2, alu_src_i2, wb_sel_i2,
           pc_src_i2, bne_i2, wen_i2, dren_i2, dwen_i2, halt_i2, aluout_i3, dstore_i3,
           lui_i3, branch_addr_i3, jump_addr_i3, jr_addr_i3, wsel_i3, wb_sel_i3,
           pc_src_i3, wen_i3, dren_i3, dwen_i3, halt_i3, aluout_i4, dload_i4, lui_i4,
           wsel_i4, wb_sel_i4, wen_i4,
    input  npc_o1, instr_o1, npc_o2, rdat1_o2, rdat2_o2, ext32_o2, lui_o2, shamt_o2,
           jaddr26_o2, wsel_o2, alu_op_o2, alu_src_o2, wb_sel_o2, pc_src_o2, bne_o2,
           wen_o2, dren_o2, dwen_o2, halt_o2, aluout_o3, dstore_o3, lui_o3,
           branch_addr_o3, jump_addr_o3, jr_addr_o3, wsel_o3, wb_sel_o3, pc_src_o3,
           wen_o3, dren_o3, dwen_o3, halt_o, aluout_o4, dload_o4, lui_o4, wsel_o4,
           wb_sel_o4, wen_o4
  );

  modport hu (
    input rsel1_o2, rsel2_o2, wsel_o2, dren_o2, wen_o3, wsel_o3
  );

endinterface

// File: verilog/cpu_types_pkg.sv
// shared cpu types
// data word, register index, opcode and funct codes
// control selects for alu, next pc, writeback and forwarding
`include "cpu_macros.svh"

package cpu_types_pkg;

  typedef logic [`WORD_W-1:0] word_t;
  typedef logic [$clog2(`REG_N)-1:0] regsel_t;

  // instr[31:26]
  typedef enum logic [5:0] {
    RTYPE = 6'h00,
    J     = 6'h02,
    BEQ   = 6'h04,
    BNE   = 6'h05,
    ADDIU = 6'h09,
    ORI   = 6'h0D,
    LUI   = 6'h0F,
    LW    = 6'h23,
    SW    = 6'h2B,
    HALT  = 6'h3F
  } opcode_t;

  // instr[5:0] of rtype
  typedef enum logic [5:0] {
    SLL  = 6'h00,
    JR   = 6'h08,
    ADDU = 6'h21,
    SUBU = 6'h23,
    AND  = 6'h24,
    OR   = 6'h25,
    SLT  = 6'h2A
  } funct_t;

  typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_SLL} alu_op_t;

  // add4 also marks a not taken branch once past execute
  typedef enum logic [1:0] {PC_ADD4, PC_BRANCH, PC_JUMP, PC_JR} pc_src_t;

  typedef enum logic [1:0] {WB_ALUOUT, WB_DATA, WB_LUI} wb_sel_t;

  typedef enum logic [1:0] {SRC_RDAT2, SRC_SHAMT, SRC_EXT} alu_src_t;

  typedef enum logic [1:0] {FWD_RDAT, FWD_EXMEM, FWD_MEMWB} fwd_sel_t;

endpackage

// File: verilog/cpu_macros.svh
// global sizing for the pipelined cpu
// word width, register count, fetch address after reset
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// data and address width
`define WORD_W 32

// architectural registers, r0 included
`define REG_N 32

// first fetch address
`define PC_RESET 32'h0000_0000

`endif
